/* hdl/ecc_pkg.sv */
package ecc_pkg;

    localparam int APB_DATA_W = 32;

    // operand regions, word k at base + 4*k
    localparam logic [11:0] ADDR_X  = 12'h000;
    localparam logic [11:0] ADDR_Y  = 12'h040;
    localparam logic [11:0] ADDR_Z  = 12'h080;
    localparam logic [11:0] ADDR_M  = 12'h0C0;

    // result regions, read only
    localparam logic [11:0] ADDR_RX = 12'h100;
    localparam logic [11:0] ADDR_RY = 12'h140;

    localparam logic [11:0] ADDR_CTRL   = 12'h180; // bit 0 starts a conversion
    localparam logic [11:0] ADDR_STATUS = 12'h184;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [11:0]           paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // also bits 2:0 of STATUS
    typedef struct packed {
        logic busy;
        logic done;
        logic at_infinity;
    } conv_status_t;

endpackage

/* hdl/mod_mul.sv */
`timescale 1ns/1ps

module mod_mul #(
    parameter int WIDTH = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic [WIDTH-1:0] m,
    output logic [WIDTH-1:0] p,
    output logic             done
);
    localparam int CW = $clog2(WIDTH);

    logic [WIDTH+1:0] acc;      // running sum, kept below m
    logic [WIDTH+1:0] dbl;      // a * 2^i mod m
    logic [WIDTH-1:0] b_sh;
    logic [CW-1:0]    cnt;
    logic             run;

    logic [WIDTH+1:0] m_ext;
    logic [WIDTH+1:0] acc_sum;
    logic [WIDTH+1:0] acc_sub;
    logic [WIDTH+1:0] acc_nxt;
    logic [WIDTH+1:0] dbl_two;
    logic [WIDTH+1:0] dbl_sub;
    logic [WIDTH+1:0] dbl_nxt;

    always_comb begin
        m_ext   = {2'b00, m};
        acc_sum = acc + dbl;
        acc_sub = acc_sum - m_ext;
        acc_nxt = b_sh[0] ? (acc_sub[WIDTH+1] ? acc_sum : acc_sub) : acc;
        dbl_two = {dbl[WIDTH:0], 1'b0};
        dbl_sub = dbl_two - m_ext;
        dbl_nxt = dbl_sub[WIDTH+1] ? dbl_two : dbl_sub; // one reduction is enough
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                if (cnt == CW'(WIDTH - 1)) begin // last bit of b
                    run  <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc  <= '0;
            dbl  <= {2'b00, a};
            b_sh <= b;
        end else if (run) begin
            acc  <= acc_nxt;
            dbl  <= dbl_nxt;
            b_sh <= b_sh >> 1;
        end
    end

    assign p = acc[WIDTH-1:0];

endmodule

/* hdl/mod_div.sv */
`timescale 1ns/1ps

// c = b * a^-1 mod m, binary extended Euclid
module mod_div #(
    parameter int WIDTH = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [WIDTH-1:0] b,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] m,
    output logic [WIDTH-1:0] c,
    output logic             done
);
    localparam int RW = WIDTH + 4;

    logic signed [RW-1:0] u;
    logic signed [RW-1:0] v;
    logic signed [RW-1:0] x;    // x * a == b * u
    logic signed [RW-1:0] y;    // y * a == b * v
    logic                 run;

    logic signed [RW-1:0] m_s;
    logic signed [RW-1:0] u_dif;
    logic signed [RW-1:0] v_dif;
    logic signed [RW-1:0] sel;
    logic signed [RW-1:0] fix;
    logic signed [RW-1:0] fix_m;
    logic signed [RW-1:0] fix_2m;
    logic signed [RW-1:0] res;
    logic                 fin;

    // halve modulo m, m is odd
    function automatic logic signed [RW-1:0] half_mod(
        input logic signed [RW-1:0] val,
        input logic signed [RW-1:0] md
    );
        logic signed [RW-1:0] t;
        t = val[0] ? val + md : val;
        return t >>> 1;
    endfunction

    always_comb begin
        m_s    = $signed({4'b0000, m});
        u_dif  = u - v;
        v_dif  = v - u;
        fin    = (u == 1) || (v == 1);
        sel    = (u == 1) ? x : y;
        fix    = (sel < 0) ? sel + m_s : sel;  // sign fix
        fix_m  = fix - m_s;
        fix_2m = fix - (m_s <<< 1);
        if (fix_2m >= 0)
            res = fix_2m;
        else if (fix_m >= 0)
            res = fix_m;
        else
            res = fix;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                run <= 1'b1;
            end else if (run && fin) begin
                run  <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            u <= $signed({4'b0000, a});
            v <= $signed({4'b0000, m});
            x <= $signed({4'b0000, b});
            y <= '0;
        end else if (run) begin
            if (fin) begin
                c <= res[WIDTH-1:0];
            end else if (!u[0] || !v[0]) begin
                if (!u[0]) begin
                    u <= u >>> 1;
                    x <= half_mod(x, m_s);
                end
                if (!v[0]) begin
                    v <= v >>> 1;
                    y <= half_mod(y, m_s);
                end
            end else if (u >= v) begin
                u <= u_dif >>> 1;   // difference of odds is even
                x <= half_mod(x - y, m_s);
            end else begin
                v <= v_dif >>> 1;
                y <= half_mod(y - x, m_s);
            end
        end
    end

endmodule

/* hdl/affine_seq.sv */
`timescale 1ns/1ps

module affine_seq #(
    parameter int WIDTH = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [WIDTH-1:0]     jx,
    input  logic [WIDTH-1:0]     jy,
    input  logic [WIDTH-1:0]     jz,
    input  logic [WIDTH-1:0]     m,
    output logic [WIDTH-1:0]     x_aff,
    output logic [WIDTH-1:0]     y_aff,
    output ecc_pkg::conv_status_t status
);
    typedef enum logic [2:0] {S_IDLE, S_INV, S_SQ, S_PAR, S_YMUL} state_t;

    state_t state;

    logic             inv_start;
    logic             inv_done;
    logic [WIDTH-1:0] inv_c;
    logic             la_start;
    logic             la_done;
    logic [WIDTH-1:0] la_a;
    logic [WIDTH-1:0] la_b;
    logic [WIDTH-1:0] la_p;
    logic             lb_start;
    logic             lb_done;
    logic [WIDTH-1:0] lb_a;
    logic [WIDTH-1:0] lb_b;
    logic [WIDTH-1:0] lb_p;

    logic [WIDTH-1:0] zi;   // 1/Z
    logic [WIDTH-1:0] zi2;
    logic [WIDTH-1:0] zi3;
    logic             got_a;
    logic             got_b;

    mod_div #(.WIDTH(WIDTH)) i_inv (
        .clk(clk), .rst_n(rst_n), .start(inv_start),
        .b(WIDTH'(1)), .a(jz), .m(m), .c(inv_c), .done(inv_done)
    );

    mod_mul #(.WIDTH(WIDTH)) i_lane_a (
        .clk(clk), .rst_n(rst_n), .start(la_start),
        .a(la_a), .b(la_b), .m(m), .p(la_p), .done(la_done)
    );

    mod_mul #(.WIDTH(WIDTH)) i_lane_b (
        .clk(clk), .rst_n(rst_n), .start(lb_start),
        .a(lb_a), .b(lb_b), .m(m), .p(lb_p), .done(lb_done)
    );

    // lane operands, latched by the multipliers on start
    always_comb begin
        la_a = '0;
        la_b = '0;
        lb_a = '0;
        lb_b = '0;
        case (state)
            S_SQ: begin
                la_a = zi;
                la_b = zi;
            end
            S_PAR: begin
                la_a = jx;
                la_b = zi2;
                lb_a = zi;
                lb_b = zi2;
            end
            S_YMUL: begin
                lb_a = jy;
                lb_b = zi3;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            inv_start <= 1'b0;
            la_start  <= 1'b0;
            lb_start  <= 1'b0;
            got_a     <= 1'b0;
            got_b     <= 1'b0;
            status    <= '0;
            x_aff     <= '0;
            y_aff     <= '0;
        end else begin
            inv_start <= 1'b0;
            la_start  <= 1'b0;
            lb_start  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        if (jz == '0) begin // point at infinity
                            status.done        <= 1'b1;
                            status.at_infinity <= 1'b1;
                            x_aff              <= '0;
                            y_aff              <= '0;
                        end else begin
                            status.busy        <= 1'b1;
                            status.done        <= 1'b0;
                            status.at_infinity <= 1'b0;
                            inv_start          <= 1'b1;
                            state              <= S_INV;
                        end
                    end
                end
                S_INV: begin
                    if (inv_done) begin
                        la_start <= 1'b1;
                        state    <= S_SQ;
                    end
                end
                S_SQ: begin
                    if (la_done) begin
                        la_start <= 1'b1;
                        lb_start <= 1'b1;
                        state    <= S_PAR;
                    end
                end
                S_PAR: begin
                    if (la_done) begin
                        x_aff <= la_p;
                        got_a <= 1'b1;
                    end
                    if (lb_done)
                        got_b <= 1'b1;
                    if ((got_a || la_done) && (got_b || lb_done)) begin
                        got_a    <= 1'b0;
                        got_b    <= 1'b0;
                        lb_start <= 1'b1;
                        state    <= S_YMUL;
                    end
                end
                S_YMUL: begin
                    if (lb_done) begin
                        y_aff       <= lb_p;
                        status.busy <= 1'b0;
                        status.done <= 1'b1;
                        state       <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // intermediate powers of 1/Z
    always_ff @(posedge clk) begin
        if (state == S_INV && inv_done)
            zi <= inv_c;
        if (state == S_SQ && la_done)
            zi2 <= la_p;
        if (state == S_PAR && lb_done)
            zi3 <= lb_p;
    end

endmodule

/* hdl/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs #(
    parameter int WIDTH = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ecc_pkg::apb_req_t     apb_req,
    output ecc_pkg::apb_rsp_t     apb_rsp,
    output logic [WIDTH-1:0]      jx,
    output logic [WIDTH-1:0]      jy,
    output logic [WIDTH-1:0]      jz,
    output logic [WIDTH-1:0]      m,
    output logic                  start,
    input  logic [WIDTH-1:0]      x_aff,
    input  logic [WIDTH-1:0]      y_aff,
    input  ecc_pkg::conv_status_t status
);
    localparam int DW = ecc_pkg::APB_DATA_W;
    localparam int NW = WIDTH / DW;     // words per operand
    localparam int SW = $bits(ecc_pkg::conv_status_t);

    logic          access;
    logic [5:0]    region;
    logic [3:0]    widx;
    logic          word_ok;
    logic          hit_x;
    logic          hit_y;
    logic          hit_z;
    logic          hit_m;
    logic          hit_rx;
    logic          hit_ry;
    logic          hit_ctrl;
    logic          hit_stat;
    logic          mapped;
    logic          ro_hit;
    logic          busy_now;
    logic          err;
    logic          wr_ok;
    logic [DW-1:0] rdata;

    always_comb begin
        access   = apb_req.psel && apb_req.penable;
        region   = apb_req.paddr[11:6];
        widx     = apb_req.paddr[5:2];
        word_ok  = (apb_req.paddr[1:0] == 2'b00) && (int'(widx) < NW);
        hit_x    = word_ok && (region == ecc_pkg::ADDR_X[11:6]);
        hit_y    = word_ok && (region == ecc_pkg::ADDR_Y[11:6]);
        hit_z    = word_ok && (region == ecc_pkg::ADDR_Z[11:6]);
        hit_m    = word_ok && (region == ecc_pkg::ADDR_M[11:6]);
        hit_rx   = word_ok && (region == ecc_pkg::ADDR_RX[11:6]);
        hit_ry   = word_ok && (region == ecc_pkg::ADDR_RY[11:6]);
        hit_ctrl = apb_req.paddr == ecc_pkg::ADDR_CTRL;
        hit_stat = apb_req.paddr == ecc_pkg::ADDR_STATUS;
        mapped   = hit_x || hit_y || hit_z || hit_m || hit_rx || hit_ry
                   || hit_ctrl || hit_stat;
        ro_hit   = hit_rx || hit_ry || hit_stat;
        busy_now = status.busy || start;   // start already on its way
        err      = access && (!mapped || (apb_req.pwrite && (ro_hit || busy_now)));
        wr_ok    = access && apb_req.pwrite && !err;
    end

    // read mux, CTRL reads as zero
    always_comb begin
        rdata = '0;
        if (hit_x)
            rdata = jx[widx*DW +: DW];
        else if (hit_y)
            rdata = jy[widx*DW +: DW];
        else if (hit_z)
            rdata = jz[widx*DW +: DW];
        else if (hit_m)
            rdata = m[widx*DW +: DW];
        else if (hit_rx)
            rdata = x_aff[widx*DW +: DW];
        else if (hit_ry)
            rdata = y_aff[widx*DW +: DW];
        else if (hit_stat)
            rdata = {{(DW - SW){1'b0}}, status};
    end

    always_comb begin
        apb_rsp.prdata  = rdata;
        apb_rsp.pready  = 1'b1;     // no wait states
        apb_rsp.pslverr = err;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jx    <= '0;
            jy    <= '0;
            jz    <= '0;
            m     <= '0;
            start <= 1'b0;
        end else begin
            if (wr_ok) begin
                if (hit_x)
                    jx[widx*DW +: DW] <= apb_req.pwdata;
                if (hit_y)
                    jy[widx*DW +: DW] <= apb_req.pwdata;
                if (hit_z)
                    jz[widx*DW +: DW] <= apb_req.pwdata;
                if (hit_m)
                    m[widx*DW +: DW] <= apb_req.pwdata;
            end
            start <= wr_ok && hit_ctrl && apb_req.pwdata[0]; // one cycle pulse
        end
    end

endmodule

/* hdl/ecc_affine_top.sv */
`timescale 1ns/1ps

// Jacobian to affine converter behind an APB slave
module ecc_affine_top #(
    parameter int WIDTH = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  ecc_pkg::apb_req_t apb_req,
    output ecc_pkg::apb_rsp_t apb_rsp
);
    logic [WIDTH-1:0]      jx;
    logic [WIDTH-1:0]      jy;
    logic [WIDTH-1:0]      jz;
    logic [WIDTH-1:0]      m;
    logic                  start;
    logic [WIDTH-1:0]      x_aff;
    logic [WIDTH-1:0]      y_aff;
    ecc_pkg::conv_status_t status;

    apb_regs #(
        .WIDTH(WIDTH)
    ) i_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .jx      (jx),
        .jy      (jy),
        .jz      (jz),
        .m       (m),
        .start   (start),
        .x_aff   (x_aff),
        .y_aff   (y_aff),
        .status  (status)
    );

    affine_seq #(
        .WIDTH(WIDTH)
    ) i_seq (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .jx      (jx),
        .jy      (jy),
        .jz      (jz),
        .m       (m),
        .x_aff   (x_aff),
        .y_aff   (y_aff),
        .status  (status)
    );

endmodule

/* bench/tb_ref_math.svh */
`ifndef TB_REF_MATH_SVH
`define TB_REF_MATH_SVH

// included inside the testbench module, sized by its WIDTH

// a * b mod md through a double-width product
function automatic logic [WIDTH-1:0] mul_mod(input logic [WIDTH-1:0] a,
                                             input logic [WIDTH-1:0] b,
                                             input logic [WIDTH-1:0] md);
    logic [2*WIDTH-1:0] prod;
    logic [2*WIDTH-1:0] rem;
    prod = {{WIDTH{1'b0}}, a} * {{WIDTH{1'b0}}, b};
    rem  = prod % {{WIDTH{1'b0}}, md};
    return rem[WIDTH-1:0];
endfunction

// left to right square and multiply
function automatic logic [WIDTH-1:0] pow_mod(input logic [WIDTH-1:0] base,
                                             input logic [WIDTH-1:0] e,
                                             input logic [WIDTH-1:0] md);
    logic [WIDTH-1:0] r;
    int               i;
    r = WIDTH'(1);
    for (i = WIDTH - 1; i >= 0; i--) begin
        r = mul_mod(r, r, md);
        if (e[i])
            r = mul_mod(r, base, md);
    end
    return r;
endfunction

// z^(m-2), valid for a prime modulus
function automatic logic [WIDTH-1:0] inv_fermat(input logic [WIDTH-1:0] z,
                                                input logic [WIDTH-1:0] md);
    return pow_mod(z, md - WIDTH'(2), md);
endfunction

// x = X / Z^2, y = Y / Z^3
task automatic affine_expect(input  logic [WIDTH-1:0] x,
                             input  logic [WIDTH-1:0] y,
                             input  logic [WIDTH-1:0] z,
                             input  logic [WIDTH-1:0] md,
                             output logic [WIDTH-1:0] ax,
                             output logic [WIDTH-1:0] ay);
    logic [WIDTH-1:0] zi;
    logic [WIDTH-1:0] zi2;
    logic [WIDTH-1:0] zi3;
    zi  = inv_fermat(z, md);
    zi2 = mul_mod(zi, zi, md);
    zi3 = mul_mod(zi2, zi, md);
    ax  = mul_mod(x, zi2, md);
    ay  = mul_mod(y, zi3, md);
endtask

`endif

/* bench/tb_ecc_affine.sv */
`timescale 1ns/1ps

module tb_ecc_affine;
    localparam int WIDTH    = 256;
    localparam int NW       = WIDTH / 32;
    localparam int N_CONV   = 8;
    localparam int CONV_MAX = 3 * (WIDTH + 1) + 2 * WIDTH + 8;   // three products plus divider
    localparam int XFER_CYC = 3 * (4 * NW + 3 * NW + 4);         // loads, readback, ctrl, polls
    // all conversions plus the readback test, five times over
    localparam int TIMEOUT_CYCLES = 5 * (N_CONV * (CONV_MAX + XFER_CYC) + 6 * NW * 4 + 10);

    localparam logic [WIDTH-1:0] P256K1 =
        256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

    logic              clk;
    logic              rst_n;
    ecc_pkg::apb_req_t apb_req;
    ecc_pkg::apb_rsp_t apb_rsp;

    int errors;
    int prop_errors;
    int cycles;
    int seed;

    `include "tb_ref_math.svh"

    ecc_affine_top #(
        .WIDTH(WIDTH)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_dut.status.busy && i_dut.status.done))
    else begin
        prop_errors++;
        $display("error at %0t ns: status.busy expected 0 while done, got %b",
                 $time, i_dut.status.busy);
    end

    task automatic check_eq(input string name, input logic [WIDTH-1:0] exp,
                            input logic [WIDTH-1:0] got);
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // setup phase, access phase, sample mid access
    task automatic bus_transfer(input logic wr, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        assert (apb_rsp.pready) else begin
            errors++;
            $display("error at %0t ns: pready expected 1, got %b", $time, apb_rsp.pready);
        end
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic slverr);
        logic [31:0] unused;
        bus_transfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic slverr);
        bus_transfer(1'b0, addr, 32'h0, data, slverr);
    endtask

    task automatic load_operand(input logic [11:0] base, input logic [WIDTH-1:0] val);
        logic err;
        int   k;
        for (k = 0; k < NW; k++) begin
            apb_write(base + 12'(4 * k), val[k*32 +: 32], err);
            check_eq("pslverr on operand write", '0, WIDTH'(err));
        end
    endtask

    task automatic read_operand(input logic [11:0] base, output logic [WIDTH-1:0] val);
        logic [31:0] rd;
        logic        err;
        int          k;
        for (k = 0; k < NW; k++) begin
            apb_read(base + 12'(4 * k), rd, err);
            check_eq("pslverr on word read", '0, WIDTH'(err));
            val[k*32 +: 32] = rd;
        end
    endtask

    task automatic random_word(output logic [WIDTH-1:0] v);
        int k;
        for (k = 0; k < NW; k++)
            v[k*32 +: 32] = $random(seed);
    endtask

    task automatic pick_below(input logic [WIDTH-1:0] md, output logic [WIDTH-1:0] v);
        logic [WIDTH-1:0] r;
        random_word(r);
        v = r % md;
    endtask

    task automatic start_conversion(input logic [WIDTH-1:0] x, input logic [WIDTH-1:0] y,
                                    input logic [WIDTH-1:0] z, input logic [WIDTH-1:0] md);
        logic err;
        load_operand(ecc_pkg::ADDR_X, x);
        load_operand(ecc_pkg::ADDR_Y, y);
        load_operand(ecc_pkg::ADDR_Z, z);
        load_operand(ecc_pkg::ADDR_M, md);
        apb_write(ecc_pkg::ADDR_CTRL, 32'h1, err);
        check_eq("pslverr on CTRL start", '0, WIDTH'(err));
    endtask

    // polls STATUS, the cycle counter bounds the wait
    task automatic wait_done(output ecc_pkg::conv_status_t st);
        logic [31:0] rd;
        logic        err;
        st = '0;
        while (!st.done) begin
            apb_read(ecc_pkg::ADDR_STATUS, rd, err);
            st = rd[2:0];
        end
    endtask

    task automatic finish_and_check(input logic [WIDTH-1:0] x, input logic [WIDTH-1:0] y,
                                    input logic [WIDTH-1:0] z, input logic [WIDTH-1:0] md);
        ecc_pkg::conv_status_t st;
        logic [WIDTH-1:0]      rx;
        logic [WIDTH-1:0]      ry;
        logic [WIDTH-1:0]      ex;
        logic [WIDTH-1:0]      ey;
        wait_done(st);
        read_operand(ecc_pkg::ADDR_RX, rx);
        read_operand(ecc_pkg::ADDR_RY, ry);
        if (z == '0) begin
            ex = '0;    // point at infinity
            ey = '0;
        end else begin
            affine_expect(x, y, z, md, ex, ey);
        end
        check_eq("status.at_infinity", WIDTH'(z == '0), WIDTH'(st.at_infinity));
        check_eq("x_aff", ex, rx);
        check_eq("y_aff", ey, ry);
    endtask

    initial begin
        logic [31:0]      rd;
        logic             err;
        logic [WIDTH-1:0] x;
        logic [WIDTH-1:0] y;
        logic [WIDTH-1:0] z;
        logic [WIDTH-1:0] ex;
        logic [WIDTH-1:0] ey;
        logic [WIDTH-1:0] val;
        logic [WIDTH-1:0] back;
        logic [11:0]      bases [4];
        int               i;

        seed    = 32'h9c63aea0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        bases   = '{ecc_pkg::ADDR_X, ecc_pkg::ADDR_Y, ecc_pkg::ADDR_Z, ecc_pkg::ADDR_M};
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        apb_read(ecc_pkg::ADDR_STATUS, rd, err);
        check_eq("STATUS after reset", '0, WIDTH'(rd));
        read_operand(ecc_pkg::ADDR_RX, back);
        check_eq("x_aff after reset", '0, back);
        read_operand(ecc_pkg::ADDR_RY, back);
        check_eq("y_aff after reset", '0, back);

        for (i = 0; i < 4; i++) begin  // operand register readback
            random_word(val);
            load_operand(bases[i], val);
            read_operand(bases[i], back);
            check_eq("operand readback", val, back);
        end

        pick_below(P256K1, x);
        pick_below(P256K1, y);
        start_conversion(x, y, WIDTH'(1), P256K1);
        finish_and_check(x, y, WIDTH'(1), P256K1);

        repeat (5) begin
            pick_below(P256K1, x);
            pick_below(P256K1, y);
            pick_below(P256K1 - WIDTH'(1), z);
            z = z + WIDTH'(1);                     // 1 .. m-1
            start_conversion(x, y, z, P256K1);
            finish_and_check(x, y, z, P256K1);
        end

        start_conversion(x, y, '0, P256K1);
        finish_and_check(x, y, '0, P256K1);

        // refused accesses around one conversion
        pick_below(P256K1, x);
        pick_below(P256K1, y);
        pick_below(P256K1 - WIDTH'(1), z);
        z = z + WIDTH'(1);
        start_conversion(x, y, z, P256K1);
        apb_write(ecc_pkg::ADDR_CTRL, 32'h1, err);
        check_eq("pslverr on CTRL write while busy", WIDTH'(1), WIDTH'(err));
        apb_write(ecc_pkg::ADDR_X, ~x[31:0], err);
        check_eq("pslverr on X write while busy", WIDTH'(1), WIDTH'(err));
        finish_and_check(x, y, z, P256K1);
        read_operand(ecc_pkg::ADDR_X, back);
        check_eq("X after refused write", x, back);

        affine_expect(x, y, z, P256K1, ex, ey);
        apb_write(ecc_pkg::ADDR_RX, ~ex[31:0], err);
        check_eq("pslverr on RX write", WIDTH'(1), WIDTH'(err));
        apb_read(ecc_pkg::ADDR_RX, rd, err);
        check_eq("RX word 0 after refused write", WIDTH'(ex[31:0]), WIDTH'(rd));
        apb_read(12'h1F0, rd, err);
        check_eq("pslverr on unmapped read", WIDTH'(1), WIDTH'(err));
        apb_write(12'h1F0, 32'h1, err);
        check_eq("pslverr on unmapped write", WIDTH'(1), WIDTH'(err));
        apb_read(ecc_pkg::ADDR_STATUS, rd, err);
        check_eq("STATUS after refused accesses", WIDTH'(32'h2), WIDTH'(rd)); // done only

        $display("checks finished: %0d errors, %0d property errors", errors, prop_errors);
        if (errors == 0 && prop_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+bench
hdl/ecc_pkg.sv
hdl/mod_mul.sv
hdl/mod_div.sv
hdl/affine_seq.sv
hdl/apb_regs.sv
hdl/ecc_affine_top.sv
bench/tb_ecc_affine.sv

/* Makefile */
# Verilator build and run of the Jacobian to affine converter testbench

VERILATOR ?= verilator
TOP       ?= tb_ecc_affine
SEED_ARGS ?= +verilator+seed+1
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f project.f
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)
